//--- hw/byteAssembler.sv
`timescale 1ns/1ps

module byteAssembler (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             byteValid,
    input  logic [7:0]                       byteIn,
    input  logic [z80Pkg::groupWidth-1:0]    decGroup,
    input  logic [z80Pkg::lenWidth-1:0]      decLen,
    output logic [z80Pkg::windowWidth-1:0]   window,
    output logic [z80Pkg::opLenWidth-1:0]    opLen,
    output logic                             complete,
    output logic [z80Pkg::windowWidth-1:0]   doneWindow,
    output logic [z80Pkg::groupWidth-1:0]    doneGroup,
    output logic [z80Pkg::lenWidth-1:0]      doneLen
);

    logic [z80Pkg::windowWidth-1:0] storedWindow;
    logic [z80Pkg::lenWidth-1:0]    count;
    logic [z80Pkg::lenWidth-1:0]    nextCount;

    assign nextCount = count + z80Pkg::lenWidth'(byteValid);

    // incoming byte lands at the next free position, little-endian
    always_comb begin
        window = storedWindow;
        if (byteValid) begin
            window[8*count[1:0] +: 8] = byteIn;
        end
    end

    // decoder only needs to know about the first two bytes
    assign opLen = (nextCount >= 3'd2) ? 2'd2 : nextCount[1:0];

    assign complete = byteValid && (nextCount == decLen)
                      && (decGroup != z80Pkg::groupNeedMoreBytes);

    assign doneWindow = window;
    assign doneGroup = decGroup;
    assign doneLen = decLen;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
            storedWindow <= '0;
        end else if (complete) begin
            count <= '0;
            storedWindow <= '0;
        end else if (byteValid) begin
            count <= nextCount;
            storedWindow <= window;
        end
    end

endmodule

//--- hw/instrLengthDecoder.sv
`timescale 1ns/1ps

module instrLengthDecoder (
    input  logic [z80Pkg::windowWidth-1:0] window,
    input  logic [z80Pkg::opLenWidth-1:0]  opLen,
    output logic [z80Pkg::groupWidth-1:0]  decGroup,
    output logic [z80Pkg::lenWidth-1:0]    decLen
);

    logic [15:0] prefixOp;
    logic        prefixed;

    // prefix in the upper byte reads like the opcode listing
    assign prefixOp = {window[7:0], window[15:8]};

    // operand bytes after an unprefixed opcode leave its class unchanged
    assign prefixed = (window[7:0] == 8'hCB) || (window[7:0] == 8'hDD)
                      || (window[7:0] == 8'hED) || (window[7:0] == 8'hFD);

    always_comb begin
        if (opLen == 2'd0) begin
            decGroup = z80Pkg::groupNeedMoreBytes;
        end else if (opLen == 2'd1 || !prefixed) begin
            casez (window[7:0])
                8'h00: decGroup = z80Pkg::groupNop;
                8'h08: decGroup = z80Pkg::groupExAfAf2;
                8'h22: decGroup = z80Pkg::groupLdIndNnHl;
                8'h2A: decGroup = z80Pkg::groupLdHlIndNn;
                8'h32: decGroup = z80Pkg::groupLdIndNnA;
                8'h3A: decGroup = z80Pkg::groupLdAIndNn;
                8'h27: decGroup = z80Pkg::groupDaa;
                8'h2F: decGroup = z80Pkg::groupCpl;
                8'h37: decGroup = z80Pkg::groupScf;
                8'h3F: decGroup = z80Pkg::groupCcf;
                8'h34, 8'h35: decGroup = z80Pkg::groupIncDecIndHl;
                8'h36: decGroup = z80Pkg::groupLdIndHlN;
                8'b00??0001: decGroup = z80Pkg::groupLdDdNn;
                8'b000?0010: decGroup = z80Pkg::groupLdIndBcdeA;
                8'b000?1010: decGroup = z80Pkg::groupLdAIndBcde;
                8'b00??0011, 8'b00??1011: decGroup = z80Pkg::groupIncDecDd;
                8'b00???100, 8'b00???101: decGroup = z80Pkg::groupIncDecReg;
                8'b00???110: decGroup = z80Pkg::groupLdRegN;
                8'b000??111: decGroup = z80Pkg::groupRrRlca;
                8'b00??1001: decGroup = z80Pkg::groupAddHlDd;
                8'h76: decGroup = z80Pkg::groupHalt;
                8'b01110???: decGroup = z80Pkg::groupLdIndHlReg;
                // LD r,(HL) is not decoded here
                8'b01???110: decGroup = z80Pkg::groupIllegalInstr;
                8'b01??????: decGroup = z80Pkg::groupLdRegReg;
                8'b10???110: decGroup = z80Pkg::groupAluAIndHl;
                8'b10??????: decGroup = z80Pkg::groupAluAReg;
                8'b11???110: decGroup = z80Pkg::groupAluAN;
                8'b11??0001: decGroup = z80Pkg::groupPopQq;
                8'b11??0101: decGroup = z80Pkg::groupPushQq;
                8'hE3: decGroup = z80Pkg::groupExIndSpHl;
                8'hEB: decGroup = z80Pkg::groupExDeHl;
                8'hD9: decGroup = z80Pkg::groupExx;
                8'hF9: decGroup = z80Pkg::groupLdSpHl;
                8'hF3, 8'hFB: decGroup = z80Pkg::groupEiDi;
                8'hCB, 8'hDD, 8'hED, 8'hFD: decGroup = z80Pkg::groupNeedMoreBytes;
                default: decGroup = z80Pkg::groupIllegalInstr;
            endcase
        end else begin
            casez (prefixOp)
                16'hCB06, 16'hCB0E, 16'hCB16, 16'hCB1E:
                    decGroup = z80Pkg::groupRrRlcIndHl;
                16'b11001011_000?????: decGroup = z80Pkg::groupRrRlcReg;
                16'hCB26, 16'hCB2E, 16'hCB3E: decGroup = z80Pkg::groupShiftIndHl;
                // CB 30..37 stays illegal
                16'b11001011_0010????, 16'b11001011_00111???:
                    decGroup = z80Pkg::groupShiftReg;
                16'b11001011_01???110: decGroup = z80Pkg::groupBitIndHl;
                16'b11001011_01??????: decGroup = z80Pkg::groupBitReg;
                16'b11001011_10???110: decGroup = z80Pkg::groupResIndHl;
                16'b11001011_10??????: decGroup = z80Pkg::groupResReg;
                16'b11001011_11???110: decGroup = z80Pkg::groupSetIndHl;
                16'b11001011_11??????: decGroup = z80Pkg::groupSetReg;
                16'b11101101_01??0010, 16'b11101101_01??1010:
                    decGroup = z80Pkg::groupAdcSbcHlDd;
                16'b11101101_01??1011: decGroup = z80Pkg::groupLdDdIndNn;
                16'b11101101_01??0011: decGroup = z80Pkg::groupLdIndNnDd;
                16'hED44: decGroup = z80Pkg::groupNeg;
                16'hED47: decGroup = z80Pkg::groupLdIA;
                16'hED4F: decGroup = z80Pkg::groupLdRA;
                16'hED57: decGroup = z80Pkg::groupLdAI;
                16'hED5F: decGroup = z80Pkg::groupLdAR;
                16'hED67, 16'hED6F: decGroup = z80Pkg::groupRotDec;
                16'hEDA0: decGroup = z80Pkg::groupLdi;
                16'hEDA1: decGroup = z80Pkg::groupCpi;
                16'hEDA8: decGroup = z80Pkg::groupLdd;
                16'hEDA9: decGroup = z80Pkg::groupCpd;
                16'hEDB0: decGroup = z80Pkg::groupLdir;
                16'hEDB1: decGroup = z80Pkg::groupCpir;
                16'hEDB8: decGroup = z80Pkg::groupLddr;
                16'hEDB9: decGroup = z80Pkg::groupCpdr;
                // 11?11101 matches both DD and FD
                16'b11?11101_00??1001: decGroup = z80Pkg::groupAddIxiySs;
                16'b11?11101_0010?011: decGroup = z80Pkg::groupIncDecIxiy;
                16'b11?11101_00100001: decGroup = z80Pkg::groupLdIxiyNn;
                16'b11?11101_00100010: decGroup = z80Pkg::groupLdIndNnIxiy;
                16'b11?11101_00101010: decGroup = z80Pkg::groupLdIxiyIndNn;
                16'b11?11101_0011010?: decGroup = z80Pkg::groupIncDecIdxIxiy;
                16'b11?11101_00110110: decGroup = z80Pkg::groupLdIdxIxiyN;
                16'b11?11101_01110110: decGroup = z80Pkg::groupIllegalInstr;
                16'b11?11101_01110???: decGroup = z80Pkg::groupLdIdxIxiyReg;
                16'b11?11101_01???110: decGroup = z80Pkg::groupLdRegIdxIxiy;
                16'b11?11101_10???110: decGroup = z80Pkg::groupAluAIdxIxiy;
                16'b11?11101_11100011: decGroup = z80Pkg::groupExIndSpIxiy;
                16'b11?11101_11100001: decGroup = z80Pkg::groupPopIxiy;
                16'b11?11101_11100101: decGroup = z80Pkg::groupPushIxiy;
                16'b11?11101_11111001: decGroup = z80Pkg::groupLdSpIxiy;
                // displacement then the real opcode follow
                16'b11?11101_11001011: decGroup = z80Pkg::groupIdxIxiyBits;
                default: decGroup = z80Pkg::groupIllegalInstr;
            endcase
        end
    end

    // total length follows from the group, operands included
    always_comb begin
        case (decGroup)
            z80Pkg::groupNeedMoreBytes: decLen = (opLen == 2'd0) ? 3'd1 : 3'd2;
            z80Pkg::groupLdRegN, z80Pkg::groupLdIndHlN, z80Pkg::groupAluAN:
                decLen = 3'd2;
            z80Pkg::groupLdDdNn, z80Pkg::groupLdIndNnHl, z80Pkg::groupLdHlIndNn,
            z80Pkg::groupLdIndNnA, z80Pkg::groupLdAIndNn, z80Pkg::groupLdRegIdxIxiy,
            z80Pkg::groupLdIdxIxiyReg, z80Pkg::groupIncDecIdxIxiy,
            z80Pkg::groupAluAIdxIxiy:
                decLen = 3'd3;
            z80Pkg::groupLdDdIndNn, z80Pkg::groupLdIndNnDd, z80Pkg::groupLdIxiyNn,
            z80Pkg::groupLdIxiyIndNn, z80Pkg::groupLdIdxIxiyN, z80Pkg::groupLdIndNnIxiy,
            z80Pkg::groupIdxIxiyBits:
                decLen = 3'd4;
            // illegal and plain opcodes: one byte alone, two after a prefix
            default: decLen = (opLen == 2'd1) ? 3'd1 : 3'd2;
        endcase
    end

endmodule

//--- hw/instrResult.sv
`timescale 1ns/1ps

module instrResult (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             complete,
    input  logic [z80Pkg::windowWidth-1:0]   doneWindow,
    input  logic [z80Pkg::groupWidth-1:0]    doneGroup,
    input  logic [z80Pkg::lenWidth-1:0]      doneLen,
    input  logic [z80Pkg::groupWidth-1:0]    bitsGroup,
    output logic                             instrValid,
    output logic [z80Pkg::groupWidth-1:0]    instrGroup,
    output logic [z80Pkg::lenWidth-1:0]      instrLen,
    output logic [z80Pkg::windowWidth-1:0]   instrBytes
);

    logic [z80Pkg::groupWidth-1:0] finalGroup;

    // indexed CB forms take their group from the fourth byte
    assign finalGroup = (doneGroup == z80Pkg::groupIdxIxiyBits) ? bitsGroup : doneGroup;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrValid <= 1'b0;
        end else begin
            instrValid <= complete;
        end
    end

    always_ff @(posedge clk) begin
        if (complete) begin
            instrGroup <= finalGroup;
            instrLen <= doneLen;
            instrBytes <= doneWindow;
        end
    end

endmodule

//--- hw/ixiyBitsDecoder.sv
`timescale 1ns/1ps

module ixiyBitsDecoder (
    input  logic [7:0]                    opByte,
    output logic [z80Pkg::groupWidth-1:0] bitsGroup
);

    // only the (IX+d) / (IY+d) operand forms exist, low bits 110
    always_comb begin
        casez (opByte)
            8'h06, 8'h0E, 8'h16, 8'h1E: bitsGroup = z80Pkg::groupRrRlcIdxIxiy;
            8'h26, 8'h2E, 8'h3E: bitsGroup = z80Pkg::groupShiftIdxIxiy;
            8'b01???110: bitsGroup = z80Pkg::groupBitIdxIxiy;
            8'b10???110: bitsGroup = z80Pkg::groupResIdxIxiy;
            8'b11???110: bitsGroup = z80Pkg::groupSetIdxIxiy;
            default: bitsGroup = z80Pkg::groupIllegalInstr;
        endcase
    end

endmodule

//--- hw/z80FrontEnd.sv
`timescale 1ns/1ps

module z80FrontEnd (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             byteValid,
    input  logic [7:0]                       byteIn,
    output logic                             instrValid,
    output logic [z80Pkg::groupWidth-1:0]    instrGroup,
    output logic [z80Pkg::lenWidth-1:0]      instrLen,
    output logic [z80Pkg::windowWidth-1:0]   instrBytes
);

    logic [z80Pkg::windowWidth-1:0] window;
    logic [z80Pkg::opLenWidth-1:0]  opLen;
    logic [z80Pkg::groupWidth-1:0]  decGroup;
    logic [z80Pkg::lenWidth-1:0]    decLen;
    logic                           complete;
    logic [z80Pkg::windowWidth-1:0] doneWindow;
    logic [z80Pkg::groupWidth-1:0]  doneGroup;
    logic [z80Pkg::lenWidth-1:0]    doneLen;
    logic [z80Pkg::groupWidth-1:0]  bitsGroup;

    byteAssembler assembler (
        .clk(clk), .arstN(arstN), .byteValid(byteValid), .byteIn(byteIn),
        .decGroup(decGroup), .decLen(decLen), .window(window), .opLen(opLen),
        .complete(complete), .doneWindow(doneWindow), .doneGroup(doneGroup),
        .doneLen(doneLen)
    );

    instrLengthDecoder lengthDecoder (
        .window(window), .opLen(opLen), .decGroup(decGroup), .decLen(decLen)
    );

    ixiyBitsDecoder bitsDecoder (
        .opByte(doneWindow[31:24]), .bitsGroup(bitsGroup)
    );

    instrResult result (
        .clk(clk), .arstN(arstN), .complete(complete), .doneWindow(doneWindow),
        .doneGroup(doneGroup), .doneLen(doneLen), .bitsGroup(bitsGroup),
        .instrValid(instrValid), .instrGroup(instrGroup), .instrLen(instrLen),
        .instrBytes(instrBytes)
    );

endmodule

//--- hw/z80Pkg.sv
package z80Pkg;

    localparam int groupWidth = 8;
    localparam int lenWidth = 3;
    localparam int windowWidth = 32;
    localparam int opLenWidth = 2;

    // unprefixed opcodes
    localparam logic [groupWidth-1:0]
        groupNop = 8'h00,
        groupLdDdNn = 8'h01,
        groupLdIndBcdeA = 8'h02,
        groupIncDecDd = 8'h03,
        groupIncDecReg = 8'h04,
        groupRrRlca = 8'h05,
        groupAddHlDd = 8'h06,
        groupDaa = 8'h07,
        groupCpl = 8'h08,
        groupIncDecIndHl = 8'h09,
        groupLdAIndBcde = 8'h0A,
        groupLdRegN = 8'h0B,
        groupLdIndNnHl = 8'h0C,
        groupLdHlIndNn = 8'h0D,
        groupLdIndHlN = 8'h0E,
        groupLdRegReg = 8'h0F,
        groupLdIndNnA = 8'h10,
        groupScf = 8'h11,
        groupLdAIndNn = 8'h12,
        groupCcf = 8'h13,
        groupLdIndHlReg = 8'h14,
        groupHalt = 8'h15,
        groupPopQq = 8'h16,
        groupPushQq = 8'h17,
        groupExAfAf2 = 8'h18,
        groupExIndSpHl = 8'h19,
        groupExDeHl = 8'h1A,
        groupExx = 8'h1B,
        groupLdSpHl = 8'h1C,
        groupAluAReg = 8'h1D,
        groupAluAIndHl = 8'h1E,
        groupAluAN = 8'h1F,
        groupEiDi = 8'h20,
        // CB page
        groupRrRlcReg = 8'h21,
        groupRrRlcIndHl = 8'h22,
        groupShiftReg = 8'h23,
        groupShiftIndHl = 8'h24,
        groupBitReg = 8'h25,
        groupBitIndHl = 8'h26,
        groupSetReg = 8'h27,
        groupSetIndHl = 8'h28,
        groupResReg = 8'h29,
        groupResIndHl = 8'h2A,
        // ED page
        groupAdcSbcHlDd = 8'h2B,
        groupLdDdIndNn = 8'h2C,
        groupNeg = 8'h2D,
        groupLdIndNnDd = 8'h2E,
        groupLdIA = 8'h2F,
        groupLdRA = 8'h30,
        groupLdAI = 8'h31,
        groupLdAR = 8'h32,
        groupRotDec = 8'h33,
        groupLdi = 8'h34,
        groupCpi = 8'h35,
        groupLdd = 8'h36,
        groupCpd = 8'h37,
        groupLdir = 8'h38,
        groupCpir = 8'h39,
        groupLddr = 8'h3A,
        groupCpdr = 8'h3B,
        // DD and FD pages, IX and IY share a code
        groupAddIxiySs = 8'h3C,
        groupIncDecIxiy = 8'h3D,
        groupLdRegIdxIxiy = 8'h3E,
        groupLdIdxIxiyReg = 8'h3F,
        groupLdIxiyNn = 8'h40,
        groupLdIxiyIndNn = 8'h41,
        groupIncDecIdxIxiy = 8'h42,
        groupLdIdxIxiyN = 8'h43,
        groupExIndSpIxiy = 8'h44,
        groupPopIxiy = 8'h45,
        groupPushIxiy = 8'h46,
        groupLdIndNnIxiy = 8'h47,
        groupAluAIdxIxiy = 8'h48,
        groupLdSpIxiy = 8'h49,
        groupIdxIxiyBits = 8'h4A,
        // refined from the fourth byte of DD CB d op / FD CB d op
        groupRrRlcIdxIxiy = 8'h4B,
        groupShiftIdxIxiy = 8'h4C,
        groupBitIdxIxiy = 8'h4D,
        groupSetIdxIxiy = 8'h4E,
        groupResIdxIxiy = 8'h4F,
        groupNeedMoreBytes = 8'hFE,
        groupIllegalInstr = 8'hFF;

endpackage

//--- include/decodeVectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// bytes are little-endian, first byte in bits 7:0
typedef struct packed {
    logic [8*16-1:0]                  name;
    logic [z80Pkg::lenWidth-1:0]      count;
    logic [z80Pkg::windowWidth-1:0]   bytes;
    logic [z80Pkg::groupWidth-1:0]    group;
    logic [z80Pkg::lenWidth-1:0]      len;
} decodeVecT;

localparam int numVectors = 22;

localparam decodeVecT vectors [numVectors] = '{
    '{"nop", 3'd1, 32'h00000000, z80Pkg::groupNop, 3'd1},
    '{"ld b,c", 3'd1, 32'h00000041, z80Pkg::groupLdRegReg, 3'd1},
    '{"add a,b", 3'd1, 32'h00000080, z80Pkg::groupAluAReg, 3'd1},
    '{"halt", 3'd1, 32'h00000076, z80Pkg::groupHalt, 3'd1},
    '{"exx", 3'd1, 32'h000000D9, z80Pkg::groupExx, 3'd1},
    '{"ld b,n", 3'd2, 32'h00001206, z80Pkg::groupLdRegN, 3'd2},
    '{"add a,n", 3'd2, 32'h000034C6, z80Pkg::groupAluAN, 3'd2},
    '{"ld bc,nn", 3'd3, 32'h00123401, z80Pkg::groupLdDdNn, 3'd3},
    '{"ld (nn),a", 3'd3, 32'h00800032, z80Pkg::groupLdIndNnA, 3'd3},
    '{"bit 0,b", 3'd2, 32'h000040CB, z80Pkg::groupBitReg, 3'd2},
    '{"set 7,(hl)", 3'd2, 32'h0000FECB, z80Pkg::groupSetIndHl, 3'd2},
    '{"res 3,a", 3'd2, 32'h00009FCB, z80Pkg::groupResReg, 3'd2},
    '{"neg", 3'd2, 32'h000044ED, z80Pkg::groupNeg, 3'd2},
    '{"ldir", 3'd2, 32'h0000B0ED, z80Pkg::groupLdir, 3'd2},
    '{"ld bc,(nn)", 3'd4, 32'h90004BED, z80Pkg::groupLdDdIndNn, 3'd4},
    '{"ld ix,nn", 3'd4, 32'h123421DD, z80Pkg::groupLdIxiyNn, 3'd4},
    '{"ld a,(ix+d)", 3'd3, 32'h00057EDD, z80Pkg::groupLdRegIdxIxiy, 3'd3},
    '{"bit 0,(ix+d)", 3'd4, 32'h4605CBDD, z80Pkg::groupBitIdxIxiy, 3'd4},
    '{"res 0,(iy+d)", 3'd4, 32'h867FCBFD, z80Pkg::groupResIdxIxiy, 3'd4},
    '{"bad ix bits", 3'd4, 32'h0001CBDD, z80Pkg::groupIllegalInstr, 3'd4},
    '{"bad single", 3'd1, 32'h00000010, z80Pkg::groupIllegalInstr, 3'd1},
    '{"bad ed pair", 3'd2, 32'h000000ED, z80Pkg::groupIllegalInstr, 3'd2}
};

`endif

//--- verification/instrDecodeTb.sv
`timescale 1ns/1ps

module instrDecodeTb;

    `include "decodeVectors.svh"

    // worst case per entry is four bytes, each after up to three idle cycles
    localparam int timeoutLimit = numVectors * 4 * 5 + 50;

    logic                             clk;
    logic                             arstN;
    logic                             byteValid;
    logic [7:0]                       byteIn;
    logic                             instrValid;
    logic [z80Pkg::groupWidth-1:0]    instrGroup;
    logic [z80Pkg::lenWidth-1:0]      instrLen;
    logic [z80Pkg::windowWidth-1:0]   instrBytes;

    integer seed;
    integer cycleCount;
    integer mismatchCount;
    integer protocolCount;

    // entries whose last byte was strobed, with the cycle of that strobe
    int pendIdx[$];
    int pendCycle[$];

    z80FrontEnd dut (
        .clk(clk),
        .arstN(arstN),
        .byteValid(byteValid),
        .byteIn(byteIn),
        .instrValid(instrValid),
        .instrGroup(instrGroup),
        .instrLen(instrLen),
        .instrBytes(instrBytes)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("timeout: run did not finish within %0d cycles", timeoutLimit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic checkValue(
        input string       testName,
        input string       field,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (expected !== actual) begin
            mismatchCount = mismatchCount + 1;
            $display("MISMATCH %s %s: expected 0x%08h, actual 0x%08h",
                     testName, field, expected, actual);
        end
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #1;
        byteValid = 1'b0;
        byteIn = 8'h00;
    endtask

    task automatic strobeByte(input logic [7:0] value);
        @(posedge clk);
        #1;
        byteValid = 1'b1;
        byteIn = value;
    endtask

    task automatic sendEntry(input int idx, input bit useGaps);
        int gap;
        int b;
        logic [z80Pkg::windowWidth-1:0] bytes;
        bytes = vectors[idx].bytes;
        for (b = 0; b < int'(vectors[idx].count); b++) begin
            gap = 0;
            if (useGaps) begin
                gap = $unsigned($random(seed)) % 4;
            end
            repeat (gap) idleCycle();
            strobeByte(bytes[8*b +: 8]);
        end
        pendIdx.push_back(idx);
        pendCycle.push_back(cycleCount);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        string testName;
        int idx;
        if (pendIdx.size() != 0 && pendCycle[0] == cycleCount - 1) begin
            idx = pendIdx[0];
            testName = $sformatf("%0s", vectors[idx].name);
            if (instrValid) begin
                checkValue(testName, "group", 32'(vectors[idx].group), 32'(instrGroup));
                checkValue(testName, "length", 32'(vectors[idx].len), 32'(instrLen));
                checkValue(testName, "bytes", vectors[idx].bytes, instrBytes);
            end else begin
                protocolCount = protocolCount + 1;
                $display("error: instrValid missing one cycle after the last byte of %s",
                         testName);
            end
            void'(pendIdx.pop_front());
            void'(pendCycle.pop_front());
        end else if (instrValid !== 1'b0) begin
            protocolCount = protocolCount + 1;
            $display("error: instrValid pulsed in cycle %0d with no instruction completed",
                     cycleCount);
        end
    end

    initial begin
        int i;
        clk = 1'b0;
        arstN = 1'b0;
        byteValid = 1'b0;
        byteIn = 8'h00;
        seed = 66106;
        cycleCount = 0;
        mismatchCount = 0;
        protocolCount = 0;

        repeat (3) @(posedge clk);
        #1;
        arstN = 1'b1;

        // random idle gaps before every byte
        for (i = 0; i < numVectors; i++) begin
            sendEntry(i, 1'b1);
        end

        // back to back, no idle cycle between instructions
        for (i = 0; i < numVectors; i++) begin
            sendEntry(i, 1'b0);
        end
        idleCycle();

        while (pendIdx.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);

        $display("errors: %0d mismatches, %0d protocol errors", mismatchCount, protocolCount);
        if (mismatchCount == 0 && protocolCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- z80FrontEnd.f
+incdir+include
hw/z80Pkg.sv
hw/ixiyBitsDecoder.sv
hw/instrLengthDecoder.sv
hw/byteAssembler.sv
hw/instrResult.sv
hw/z80FrontEnd.sv
verification/instrDecodeTb.sv
